// File: tb.f
+incdir+hw
+incdir+testbench
hw/rv_id_pkg.sv
hw/imm_gen.sv
hw/id_ctrl.sv
hw/id_operand.sv
hw/id_ex_reg.sv
hw/id_stage.sv
testbench/tb_id_stage.sv

// File: testbench/tb_id_model.svh
// reference decode model: read data scramble, expected read addresses and execute bundle
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// instruction classes, used to aim the checks
localparam logic [2:0] K_OTHER   = 3'd0;
localparam logic [2:0] K_OP      = 3'd1;
localparam logic [2:0] K_JUMP    = 3'd2;
localparam logic [2:0] K_CSR     = 3'd3;
localparam logic [2:0] K_ILLEGAL = 3'd4;

typedef struct packed {
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [11:0] csr;
} raddr_t;

function automatic logic [31:0] reg_scramble(input logic [4:0] a);
    return (a == 5'd0) ? 32'h0 : ({a, 27'h0} ^ (32'h9e3779b9 * {27'h0, a}));  // x0 reads zero
endfunction

function automatic logic [31:0] csr_scramble(input logic [11:0] a);
    return {a, 8'h5a, a} ^ 32'h3c3c_0f0f;
endfunction

function automatic id_ex_t model_decode(input logic [31:0] w, input logic [31:0] pc,
                                        output raddr_t addr, output logic [2:0] kind);
    id_ex_t      e;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] immi;
    logic [31:0] imms;
    logic [31:0] immb;
    logic [31:0] immj;
    logic [31:0] immu;
    d1   = reg_scramble(w[19:15]);  // only used where rs1 is read
    d2   = reg_scramble(w[24:20]);
    immi = {{20{w[31]}}, w[31:20]};
    imms = {{20{w[31]}}, w[31:25], w[11:7]};
    immb = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    immj = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    immu = {w[31:12], 12'h0};
    e    = '0;
    addr = '0;
    kind = K_ILLEGAL;
    case (w[6:0])
        `INST_TYPE_I: begin
            kind           = K_OP;
            addr.r1        = w[19:15];
            e.reg_we       = 1'b1;
            e.reg_waddr    = w[11:7];
            {e.op1, e.op2} = {d1, immi};
        end
        `INST_TYPE_R_M: begin
            if (w[31:25] == 7'h00 || w[31:25] == 7'h20 || w[31:25] == 7'h01) begin
                kind           = K_OP;
                addr.r1        = w[19:15];
                addr.r2        = w[24:20];
                e.reg_waddr    = w[11:7];
                e.reg_we       = !(w[25] && w[14]);  // div/rem write back later
                {e.op1, e.op2} = {d1, d2};
                if (w[25] && w[14]) begin
                    kind                     = K_JUMP;
                    {e.op1_jump, e.op2_jump} = {pc, 32'd4};
                end
            end
        end
        `INST_TYPE_L: begin
            if (w[14:12] != 3'd3 && w[14:12] < 3'd6) begin
                kind           = K_OP;
                addr.r1        = w[19:15];
                e.reg_we       = 1'b1;
                e.reg_waddr    = w[11:7];
                {e.op1, e.op2} = {d1, immi};
            end
        end
        `INST_TYPE_S: begin
            if (w[14:12] < 3'd3) begin
                kind           = K_OP;
                addr.r1        = w[19:15];
                addr.r2        = w[24:20];
                {e.op1, e.op2} = {d1, imms};
            end
        end
        `INST_TYPE_B: begin
            if (w[14:13] != 2'b01) begin  // funct3 2 and 3 are reserved
                kind                     = K_JUMP;
                addr.r1                  = w[19:15];
                addr.r2                  = w[24:20];
                {e.op1, e.op2}           = {d1, d2};
                {e.op1_jump, e.op2_jump} = {pc, immb};
            end
        end
        `INST_JAL: begin
            kind                     = K_JUMP;
            e.reg_we                 = 1'b1;
            e.reg_waddr              = w[11:7];
            {e.op1, e.op2}           = {pc, 32'd4};
            {e.op1_jump, e.op2_jump} = {pc, immj};
        end
        `INST_JALR: begin
            kind                     = K_JUMP;
            addr.r1                  = w[19:15];
            e.reg_we                 = 1'b1;
            e.reg_waddr              = w[11:7];
            {e.op1, e.op2}           = {pc, 32'd4};
            {e.op1_jump, e.op2_jump} = {d1, immi};
        end
        `INST_LUI: begin
            kind        = K_OP;
            e.reg_we    = 1'b1;
            e.reg_waddr = w[11:7];
            e.op1       = immu;
        end
        `INST_AUIPC: begin
            kind           = K_OP;
            e.reg_we       = 1'b1;
            e.reg_waddr    = w[11:7];
            {e.op1, e.op2} = {pc, immu};
        end
        `INST_NOP_OP: kind = K_OTHER;
        `INST_FENCE: begin
            kind                     = K_JUMP;
            {e.op1_jump, e.op2_jump} = {pc, 32'd4};
        end
        `INST_CSR: begin
            if (w[13:12] != 2'b00) begin
                kind        = K_CSR;
                addr.r1     = w[14] ? 5'd0 : w[19:15];  // immediate forms read no rs1
                addr.csr    = w[31:20];
                e.reg_we    = 1'b1;
                e.reg_waddr = w[11:7];
                e.csr_we    = 1'b1;
            end
        end
        default: ;
    endcase
    e.inst       = w;
    e.inst_addr  = pc;
    e.reg1_rdata = reg_scramble(addr.r1);
    e.reg2_rdata = reg_scramble(addr.r2);
    e.csr_rdata  = csr_scramble(addr.csr);
    e.csr_waddr  = {20'h0, addr.csr};
    return e;
endfunction

`endif

// File: testbench/tb_id_stage.sv
// testbench for the decode stage: stimulus, assertion checks against the model, watchdog
`include "rv_id_cfg.svh"

module tb_id_stage
    import rv_id_pkg::*;
();

    localparam int N_RANDOM = 300;
    localparam int SEED     = 10746;

    logic               clk;
    logic               rst;
    logic [`XLEN-1:0]   inst;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   reg1_rdata;
    logic [`XLEN-1:0]   reg2_rdata;
    logic [`XLEN-1:0]   csr_rdata;
    logic               jump_flag;
    logic [`REG_AW-1:0] reg1_raddr;
    logic [`REG_AW-1:0] reg2_raddr;
    logic [`CSR_AW-1:0] csr_raddr;
    id_ex_t             id_ex;

    logic [31:0] directed[$];
    int          errors = 0;
    int          limit  = 0;

    `include "tb_id_model.svh"

    id_ex_t     exp_d;
    id_ex_t     exp_q;
    raddr_t     exp_addr;
    logic [2:0] kind_d;
    logic [2:0] kind_q;
    logic       bubble_q;

    id_stage dut_i (
        .clk            (clk),
        .rst_i          (rst),
        .inst_i         (inst),
        .inst_addr_i    (pc),
        .reg1_rdata_i   (reg1_rdata),
        .reg2_rdata_i   (reg2_rdata),
        .csr_rdata_i    (csr_rdata),
        .ex_jump_flag_i (jump_flag),
        .reg1_raddr_o   (reg1_raddr),
        .reg2_raddr_o   (reg2_raddr),
        .csr_raddr_o    (csr_raddr),
        .id_ex_o        (id_ex)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // register and csr files answer in the same cycle
    assign reg1_rdata = reg_scramble(reg1_raddr);
    assign reg2_rdata = reg_scramble(reg2_raddr);
    assign csr_rdata  = csr_scramble(csr_raddr);

    always_comb exp_d = model_decode(inst, pc, exp_addr, kind_d);

    always @(posedge clk) begin
        bubble_q <= rst || jump_flag;
        if (rst || jump_flag) begin
            exp_q  <= '0;
            kind_q <= K_OTHER;
        end else begin
            exp_q  <= exp_d;
            kind_q <= kind_d;
        end
    end

    task automatic report_mismatch(input string what);
        errors++;
        $display("FAILED %0t: %s", $time, what);
    endtask

    raddr_a: assert property (@(posedge clk)
        {reg1_raddr, reg2_raddr, csr_raddr} == exp_addr)
        else report_mismatch("read addresses differ from the model");

    ops_a: assert property (@(posedge clk) disable iff (rst)
        (!bubble_q && kind_q == K_OP) |-> (id_ex.op1 == exp_q.op1 && id_ex.op2 == exp_q.op2))
        else report_mismatch("operand pair wrong");

    jump_a: assert property (@(posedge clk) disable iff (rst)
        (!bubble_q && kind_q == K_JUMP) |->
            (id_ex.op1_jump == exp_q.op1_jump && id_ex.op2_jump == exp_q.op2_jump &&
             id_ex.reg_we == exp_q.reg_we && !id_ex.csr_we))
        else report_mismatch("jump pair or write enable wrong");

    illegal_a: assert property (@(posedge clk) disable iff (rst)
        (!bubble_q && kind_q == K_ILLEGAL) |->
            (!id_ex.reg_we && !id_ex.csr_we && id_ex.op1 == '0 && id_ex.op2 == '0 &&
             id_ex.op1_jump == '0 && id_ex.op2_jump == '0 &&
             id_ex.inst == exp_q.inst && id_ex.inst_addr == exp_q.inst_addr))
        else report_mismatch("unsupported encoding not inert");

    bubble_a: assert property (@(posedge clk) disable iff (rst)
        bubble_q |-> (id_ex == '0))
        else report_mismatch("bundle not cleared after reset or flush");

    bundle_a: assert property (@(posedge clk) disable iff (rst) id_ex == exp_q)
        else report_mismatch("registered bundle differs from the model");

    function automatic logic [31:0] pack_fields(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [6:0] pick_opcode(input int unsigned sel);
        case (sel)
            0:       return `INST_TYPE_I;
            1:       return `INST_TYPE_R_M;
            2:       return `INST_TYPE_L;
            3:       return `INST_TYPE_S;
            4:       return `INST_TYPE_B;
            5:       return `INST_JAL;
            6:       return `INST_JALR;
            7:       return `INST_LUI;
            8:       return `INST_AUIPC;
            9:       return `INST_NOP_OP;
            10:      return `INST_FENCE;
            11:      return `INST_CSR;
            12:      return 7'b1111111;
            default: return 7'($urandom);  // mostly illegal
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        w      = $urandom;
        w[6:0] = pick_opcode($urandom % 14);
        if (w[6:0] == `INST_TYPE_R_M) begin
            case ($urandom % 4)
                0:       w[31:25] = `FUNCT7_BASE;
                1:       w[31:25] = `FUNCT7_ALT;
                2:       w[31:25] = `FUNCT7_M;
                default: w[31:25] = 7'($urandom);
            endcase
        end
        return w;
    endfunction

    task automatic load_directed();
        directed.push_back(pack_fields(7'h7f, 5'h1d, 5'd1, 3'd0, 5'd5, `INST_TYPE_I));  // addi -3
        directed.push_back(pack_fields(`FUNCT7_BASE, 5'd2, 5'd1, 3'd0, 5'd3, `INST_TYPE_R_M));
        directed.push_back(pack_fields(`FUNCT7_ALT, 5'd2, 5'd1, 3'd0, 5'd3, `INST_TYPE_R_M));
        directed.push_back(pack_fields(7'h02, 5'd2, 5'd1, 3'd0, 5'd3, `INST_TYPE_R_M));
        // every funct3, legal and reserved
        for (int f = 0; f < 8; f++) begin
            directed.push_back(pack_fields(`FUNCT7_M, 5'd7, 5'd3, f[2:0], 5'd9, `INST_TYPE_R_M));
            directed.push_back(pack_fields(7'h41, 5'd0, 5'd4, f[2:0], 5'd6, `INST_TYPE_L));
            directed.push_back(pack_fields(7'h55, 5'd8, 5'd4, f[2:0], 5'd17, `INST_TYPE_S));
            directed.push_back(pack_fields(7'h6a, 5'd9, 5'd10, f[2:0], 5'd13, `INST_TYPE_B));
            directed.push_back(pack_fields(7'h30, 5'd5, 5'd11, f[2:0], 5'd12, `INST_CSR));
        end
        directed.push_back(pack_fields(7'h1a, 5'h0b, 5'h13, 3'd5, 5'd1, `INST_JAL));
        directed.push_back(pack_fields(7'h7f, 5'h18, 5'd14, 3'd0, 5'd1, `INST_JALR));
        directed.push_back(pack_fields(7'h5a, 5'h11, 5'h0c, 3'd3, 5'd20, `INST_LUI));
        directed.push_back(pack_fields(7'h01, 5'h02, 5'h03, 3'd4, 5'd21, `INST_AUIPC));
        directed.push_back(pack_fields(7'h00, 5'h00, 5'h00, 3'd0, 5'd0, `INST_NOP_OP));
        directed.push_back(pack_fields(7'h00, 5'h0f, 5'h00, 3'd0, 5'd0, `INST_FENCE));
        directed.push_back(pack_fields(7'h12, 5'd3, 5'd4, 3'd0, 5'd5, 7'b1111111));
    endtask

    task automatic apply_inst(input logic [31:0] w);
        @(negedge clk);
        inst      = w;
        pc        = pc + 32'd4;
        jump_flag = ($urandom % 8) == 0;  // flush about one cycle in eight
    endtask

    initial begin
        rst       = 1'b1;
        inst      = '0;
        pc        = '0;
        jump_flag = 1'b0;
        void'($urandom(SEED));
        load_directed();
        limit = (directed.size() + N_RANDOM + 20) * 10;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        pc  = 32'h0000_1000;
        for (int n = 0; n < directed.size() + N_RANDOM; n++) begin
            apply_inst((n < directed.size()) ? directed[n] : random_inst());
        end
        @(negedge clk);
        jump_flag = 1'b0;
        repeat (2) @(negedge clk);  // let the last bundle be checked
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (limit > 0);
        #(limit);
        $display("watchdog expired, the run timed out at %0t", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: hw/id_stage.sv
// decode stage top: decoder, immediates, operand select and id/ex register
`include "rv_id_cfg.svh"

module id_stage
    import rv_id_pkg::*;
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic [`XLEN-1:0]   inst_i,
    input  logic [`XLEN-1:0]   inst_addr_i,
    input  logic [`XLEN-1:0]   reg1_rdata_i,
    input  logic [`XLEN-1:0]   reg2_rdata_i,
    input  logic [`XLEN-1:0]   csr_rdata_i,
    input  logic               ex_jump_flag_i,
    output logic [`REG_AW-1:0] reg1_raddr_o,
    output logic [`REG_AW-1:0] reg2_raddr_o,
    output logic [`CSR_AW-1:0] csr_raddr_o,
    output id_ex_t             id_ex_o
);

    id_ctrl_t         ctrl;
    imm_t             imm;
    id_ex_t           id_ex_d;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] op1_jump;
    logic [`XLEN-1:0] op2_jump;

    id_ctrl u_ctrl (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    imm_gen u_imm (
        .inst_i (inst_i),
        .imm_o  (imm)
    );

    id_operand u_operand (
        .ctrl_i       (ctrl),
        .imm_i        (imm),
        .inst_addr_i  (inst_addr_i),
        .reg1_rdata_i (reg1_rdata_i),
        .reg2_rdata_i (reg2_rdata_i),
        .op1_o        (op1),
        .op2_o        (op2),
        .op1_jump_o   (op1_jump),
        .op2_jump_o   (op2_jump)
    );

    // register and csr files answer in the same cycle
    assign reg1_raddr_o = ctrl.reg1_raddr;
    assign reg2_raddr_o = ctrl.reg2_raddr;
    assign csr_raddr_o  = ctrl.csr_addr;

    always_comb begin
        id_ex_d.inst       = inst_i;
        id_ex_d.inst_addr  = inst_addr_i;
        id_ex_d.op1        = op1;
        id_ex_d.op2        = op2;
        id_ex_d.op1_jump   = op1_jump;
        id_ex_d.op2_jump   = op2_jump;
        id_ex_d.reg1_rdata = reg1_rdata_i;
        id_ex_d.reg2_rdata = reg2_rdata_i;
        id_ex_d.reg_we     = ctrl.reg_we;
        id_ex_d.reg_waddr  = ctrl.reg_waddr;
        id_ex_d.csr_we     = ctrl.csr_we;
        id_ex_d.csr_rdata  = csr_rdata_i;
        id_ex_d.csr_waddr  = {{(`XLEN-`CSR_AW){1'b0}}, ctrl.csr_addr};
    end

    id_ex_reg u_id_ex (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (ex_jump_flag_i),
        .d_i     (id_ex_d),
        .q_o     (id_ex_o)
    );

endmodule

// File: hw/id_ex_reg.sv
// decode-to-execute pipeline register, cleared on reset or jump flush
module id_ex_reg
    import rv_id_pkg::*;
(
    input  logic   clk,
    input  logic   rst_i,
    input  logic   flush_i,  // taken jump in execute
    input  id_ex_t d_i,
    output id_ex_t q_o
);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            q_o <= '0;  // bubble
        end else begin
            q_o <= d_i;
        end
    end

    // a flushed slot must never write back
    bubble_no_write_a: assert property (
        @(posedge clk) (rst_i || flush_i) |=> (!q_o.reg_we && !q_o.csr_we)
    ) else $error("write enable active one cycle after reset or flush");

endmodule

// File: hw/id_operand.sv
// operand pair and jump-operand pair selection
`include "rv_id_cfg.svh"

module id_operand
    import rv_id_pkg::*;
(
    input  id_ctrl_t         ctrl_i,
    input  imm_t             imm_i,
    input  logic [`XLEN-1:0] inst_addr_i,
    input  logic [`XLEN-1:0] reg1_rdata_i,
    input  logic [`XLEN-1:0] reg2_rdata_i,
    output logic [`XLEN-1:0] op1_o,
    output logic [`XLEN-1:0] op2_o,
    output logic [`XLEN-1:0] op1_jump_o,
    output logic [`XLEN-1:0] op2_jump_o
);

    always_comb begin
        op1_o = '0;
        op2_o = '0;
        case (ctrl_i.op_sel)
            OP_RS_IMMI: begin
                op1_o = reg1_rdata_i;
                op2_o = imm_i.i;
            end
            OP_RS_IMMS: begin
                op1_o = reg1_rdata_i;
                op2_o = imm_i.s;
            end
            OP_RS_RS: begin
                op1_o = reg1_rdata_i;
                op2_o = reg2_rdata_i;
            end
            OP_PC_STEP: begin  // return address
                op1_o = inst_addr_i;
                op2_o = `INST_STEP;
            end
            OP_UPPER: op1_o = imm_i.u;
            OP_PC_UPPER: begin
                op1_o = inst_addr_i;
                op2_o = imm_i.u;
            end
            default: ;
        endcase
    end

    always_comb begin
        op1_jump_o = '0;
        op2_jump_o = '0;
        case (ctrl_i.jmp_sel)
            JMP_PC_STEP: begin
                op1_jump_o = inst_addr_i;
                op2_jump_o = `INST_STEP;
            end
            JMP_PC_B: begin
                op1_jump_o = inst_addr_i;
                op2_jump_o = imm_i.b;
            end
            JMP_PC_J: begin
                op1_jump_o = inst_addr_i;
                op2_jump_o = imm_i.j;
            end
            JMP_RS_I: begin  // jalr target base
                op1_jump_o = reg1_rdata_i;
                op2_jump_o = imm_i.i;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/id_ctrl.sv
// instruction decoder: read addresses, write controls and operand selects
`include "rv_id_cfg.svh"

module id_ctrl
    import rv_id_pkg::*;
(
    input  inst_u    inst_i,
    output id_ctrl_t ctrl_o
);

    always_comb begin
        // inactive unless a supported encoding matches
        ctrl_o.reg1_raddr = '0;
        ctrl_o.reg2_raddr = '0;
        ctrl_o.reg_we     = 1'b0;
        ctrl_o.reg_waddr  = '0;
        ctrl_o.csr_we     = 1'b0;
        ctrl_o.csr_addr   = '0;
        ctrl_o.op_sel     = OP_NONE;
        ctrl_o.jmp_sel    = JMP_NONE;

        case (inst_i.r.opcode)
            `INST_TYPE_I: begin  // every funct3 is an alu op
                ctrl_o.reg1_raddr = inst_i.r.rs1;
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.reg_waddr  = inst_i.r.rd;
                ctrl_o.op_sel     = OP_RS_IMMI;
            end
            `INST_TYPE_R_M: begin
                if ((inst_i.r.funct7 == `FUNCT7_BASE) || (inst_i.r.funct7 == `FUNCT7_ALT)) begin
                    ctrl_o.reg1_raddr = inst_i.r.rs1;
                    ctrl_o.reg2_raddr = inst_i.r.rs2;
                    ctrl_o.reg_we     = 1'b1;
                    ctrl_o.reg_waddr  = inst_i.r.rd;
                    ctrl_o.op_sel     = OP_RS_RS;
                end else if (inst_i.r.funct7 == `FUNCT7_M) begin
                    ctrl_o.reg1_raddr = inst_i.r.rs1;
                    ctrl_o.reg2_raddr = inst_i.r.rs2;
                    ctrl_o.reg_waddr  = inst_i.r.rd;
                    ctrl_o.op_sel     = OP_RS_RS;
                    case (inst_i.r.funct3)
                        `INST_DIV, `INST_DIVU, `INST_REM, `INST_REMU: begin
                            // divider writes back itself later
                            ctrl_o.jmp_sel = JMP_PC_STEP;
                        end
                        default: begin  // mul, mulh, mulhsu, mulhu
                            ctrl_o.reg_we = 1'b1;
                        end
                    endcase
                end
            end
            `INST_TYPE_L: begin
                case (inst_i.r.funct3)
                    `INST_LB, `INST_LH, `INST_LW, `INST_LBU, `INST_LHU: begin
                        ctrl_o.reg1_raddr = inst_i.r.rs1;
                        ctrl_o.reg_we     = 1'b1;
                        ctrl_o.reg_waddr  = inst_i.r.rd;
                        ctrl_o.op_sel     = OP_RS_IMMI;
                    end
                    default: ;
                endcase
            end
            `INST_TYPE_S: begin
                case (inst_i.r.funct3)
                    `INST_SB, `INST_SH, `INST_SW: begin
                        ctrl_o.reg1_raddr = inst_i.r.rs1;
                        ctrl_o.reg2_raddr = inst_i.r.rs2;  // store data
                        ctrl_o.op_sel     = OP_RS_IMMS;
                    end
                    default: ;
                endcase
            end
            `INST_TYPE_B: begin
                case (inst_i.r.funct3)
                    `INST_BEQ, `INST_BNE, `INST_BLT, `INST_BGE, `INST_BLTU, `INST_BGEU: begin
                        ctrl_o.reg1_raddr = inst_i.r.rs1;
                        ctrl_o.reg2_raddr = inst_i.r.rs2;
                        ctrl_o.op_sel     = OP_RS_RS;     // compare pair
                        ctrl_o.jmp_sel    = JMP_PC_B;
                    end
                    default: ;
                endcase
            end
            `INST_JAL: begin
                ctrl_o.reg_we    = 1'b1;
                ctrl_o.reg_waddr = inst_i.r.rd;
                ctrl_o.op_sel    = OP_PC_STEP;
                ctrl_o.jmp_sel   = JMP_PC_J;
            end
            `INST_JALR: begin
                ctrl_o.reg1_raddr = inst_i.r.rs1;
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.reg_waddr  = inst_i.r.rd;
                ctrl_o.op_sel     = OP_PC_STEP;
                ctrl_o.jmp_sel    = JMP_RS_I;
            end
            `INST_LUI: begin
                ctrl_o.reg_we    = 1'b1;
                ctrl_o.reg_waddr = inst_i.r.rd;
                ctrl_o.op_sel    = OP_UPPER;
            end
            `INST_AUIPC: begin
                ctrl_o.reg_we    = 1'b1;
                ctrl_o.reg_waddr = inst_i.r.rd;
                ctrl_o.op_sel    = OP_PC_UPPER;
            end
            `INST_NOP_OP: ;  // defaults hold
            `INST_FENCE: begin
                ctrl_o.jmp_sel = JMP_PC_STEP;  // refetch next instruction
            end
            `INST_CSR: begin
                case (inst_i.r.funct3)
                    `INST_CSRRW, `INST_CSRRS, `INST_CSRRC: begin
                        ctrl_o.reg1_raddr = inst_i.i.rs1;
                        ctrl_o.reg_we     = 1'b1;
                        ctrl_o.reg_waddr  = inst_i.i.rd;
                        ctrl_o.csr_we     = 1'b1;
                        ctrl_o.csr_addr   = inst_i.i.imm12;
                    end
                    `INST_CSRRWI, `INST_CSRRSI, `INST_CSRRCI: begin  // rs1 field is uimm
                        ctrl_o.reg_we     = 1'b1;
                        ctrl_o.reg_waddr  = inst_i.i.rd;
                        ctrl_o.csr_we     = 1'b1;
                        ctrl_o.csr_addr   = inst_i.i.imm12;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // checked once the decode has settled in the time step
    always_comb begin
        csr_we_sys_a: assert final (!ctrl_o.csr_we || (inst_i.r.opcode == `INST_CSR))
            else $error("csr_we set outside the SYSTEM opcode");
        reg_we_src_a: assert final (!ctrl_o.reg_we || (ctrl_o.op_sel != OP_NONE) ||
                                    (inst_i.r.opcode == `INST_CSR))
            else $error("reg_we set without an operand source");
    end

endmodule

// File: hw/imm_gen.sv
// immediate generator: I, S, B, J and U forms, all sign-extended from bit 31
`include "rv_id_cfg.svh"

module imm_gen
    import rv_id_pkg::*;
(
    input  inst_u inst_i,
    output imm_t  imm_o
);

    logic sign;

    assign sign = inst_i.r.funct7[6];  // inst[31]

    assign imm_o.i = {{(`XLEN-12){sign}}, inst_i.i.imm12};

    assign imm_o.s = {{(`XLEN-12){sign}}, inst_i.r.funct7, inst_i.r.rd};

    // inst[7] lands on bit 11
    assign imm_o.b = {{(`XLEN-12){sign}},
                      inst_i.r.rd[0],
                      inst_i.r.funct7[5:0],
                      inst_i.r.rd[4:1],
                      1'b0};

    // inst[19:12], inst[20], inst[30:21]
    assign imm_o.j = {{(`XLEN-20){sign}},
                      inst_i.r.rs1,
                      inst_i.r.funct3,
                      inst_i.r.rs2[0],
                      inst_i.r.funct7[5:0],
                      inst_i.r.rs2[4:1],
                      1'b0};

    assign imm_o.u = {inst_i.r.funct7,
                      inst_i.r.rs2,
                      inst_i.r.rs1,
                      inst_i.r.funct3,
                      12'b0};

endmodule

// File: hw/rv_id_pkg.sv
// instruction union, operand select enums and the decode/execute bundle structs
`include "rv_id_cfg.svh"

package rv_id_pkg;

    // register-register view, also the base for S/B/J/U immediates
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]        imm12;  // also the csr address
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    typedef enum logic [2:0] {
        OP_NONE     = 3'd0,
        OP_RS_IMMI  = 3'd1,     // rs1, I immediate
        OP_RS_IMMS  = 3'd2,     // rs1, S immediate
        OP_RS_RS    = 3'd3,
        OP_PC_STEP  = 3'd4,     // link value
        OP_UPPER    = 3'd5,
        OP_PC_UPPER = 3'd6
    } op_sel_e;

    typedef enum logic [2:0] {
        JMP_NONE    = 3'd0,
        JMP_PC_STEP = 3'd1,     // resume after multi-cycle ops
        JMP_PC_B    = 3'd2,
        JMP_PC_J    = 3'd3,
        JMP_RS_I    = 3'd4
    } jmp_sel_e;

    typedef struct packed {
        logic [`XLEN-1:0] i;
        logic [`XLEN-1:0] s;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] j;
        logic [`XLEN-1:0] u;
    } imm_t;

    typedef struct packed {
        logic [`REG_AW-1:0] reg1_raddr;
        logic [`REG_AW-1:0] reg2_raddr;
        logic               reg_we;
        logic [`REG_AW-1:0] reg_waddr;
        logic               csr_we;
        logic [`CSR_AW-1:0] csr_addr;   // read and write address
        op_sel_e            op_sel;
        jmp_sel_e           jmp_sel;
    } id_ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0]   inst;
        logic [`XLEN-1:0]   inst_addr;
        logic [`XLEN-1:0]   op1;
        logic [`XLEN-1:0]   op2;
        logic [`XLEN-1:0]   op1_jump;
        logic [`XLEN-1:0]   op2_jump;
        logic [`XLEN-1:0]   reg1_rdata;
        logic [`XLEN-1:0]   reg2_rdata;
        logic               reg_we;
        logic [`REG_AW-1:0] reg_waddr;
        logic               csr_we;
        logic [`XLEN-1:0]   csr_rdata;
        logic [`XLEN-1:0]   csr_waddr;  // zero-extended csr address
    } id_ex_t;

endpackage

// File: hw/rv_id_cfg.svh
// widths, opcodes, funct codes and the pc step for the RV32IM + Zicsr decode stage
`ifndef RV_ID_CFG_SVH
`define RV_ID_CFG_SVH

`define XLEN            32
`define REG_AW          5
`define CSR_AW          12

// major opcodes
`define INST_TYPE_I     7'b0010011
`define INST_TYPE_R_M   7'b0110011
`define INST_TYPE_L     7'b0000011
`define INST_TYPE_S     7'b0100011
`define INST_TYPE_B     7'b1100011
`define INST_JAL        7'b1101111
`define INST_JALR       7'b1100111
`define INST_LUI        7'b0110111
`define INST_AUIPC      7'b0010111
`define INST_NOP_OP     7'b0000001
`define INST_FENCE      7'b0001111
`define INST_CSR        7'b1110011

`define INST_LB         3'b000
`define INST_LH         3'b001
`define INST_LW         3'b010
`define INST_LBU        3'b100
`define INST_LHU        3'b101

`define INST_SB         3'b000
`define INST_SH         3'b001
`define INST_SW         3'b010

`define INST_BEQ        3'b000
`define INST_BNE        3'b001
`define INST_BLT        3'b100
`define INST_BGE        3'b101
`define INST_BLTU       3'b110
`define INST_BGEU       3'b111

`define INST_DIV        3'b100
`define INST_DIVU       3'b101
`define INST_REM        3'b110
`define INST_REMU       3'b111

`define INST_CSRRW      3'b001
`define INST_CSRRS      3'b010
`define INST_CSRRC      3'b011
`define INST_CSRRWI     3'b101
`define INST_CSRRSI     3'b110
`define INST_CSRRCI     3'b111

`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000
`define FUNCT7_M        7'b0000001

`define INST_STEP       32'h4

`endif
